// ==== flist.f ====
hw/tai_pkg.sv
hw/tai_utc_timer_reg.sv
hw/tai_time_counter.sv
hw/tai_utc_convert.sv
hw/tai_utc_timer_top.sv
tests/tai_utc_timer_chk.sv
tests/tb_tai_utc_timer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and judge the run from its log.

cd "$(dirname "$0")" || exit 1

top=tb_tai_utc_timer
log=sim.log

rm -rf obj_dir "$log"

verilator --binary --timing --assert -j 0 --top-module "$top" -f flist.f -o "$top" \
	|| { echo "build failed"; exit 1; }

./obj_dir/"$top" +verilator+error+limit+1000 > "$log" 2>&1 \
	|| echo "simulator exited with an error status" >> "$log"
cat "$log"

grep -qF '*** FAILED ***' "$log" && { echo "result: fail"; exit 1; }
grep -qF '*** PASSED ***' "$log" || { echo "result: no pass line in $log"; exit 1; }
echo "result: pass"

// ==== tests/tb_tai_utc_timer.sv ====
`timescale 1ns/1ps

module tb_tai_utc_timer;

	import tai_pkg::*;

	localparam int          CLK_PERIOD = 40;
	localparam int          MAX_CYCLES = 800;
	localparam int unsigned SEED       = 32'h0c14_62f9;

	logic      clk;
	logic      rst_n;
	logic      io_update;
	timer_wr_t wr;
	time_out_t now;
	logic      pps;

	// committed fields as the testbench expects them.
	timer_cfg_t mdl;
	int         err_cnt   = 0;
	int         cycle_cnt = 0;
	int         pps_cnt   = 0;

	tai_utc_timer_top u_tai_utc_timer_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.io_update (io_update),
		.wr        (wr),
		.now       (now),
		.pps       (pps)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// --------------------------------------------------
	// cycle limit and pulse count
	// --------------------------------------------------

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (pps) begin
			pps_cnt <= pps_cnt + 1;
		end
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	task automatic report_error(input string msg);
		err_cnt++;
		$display("** Error @%0t: %s", $time, msg);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp)
		else report_error($sformatf("%s is %0h, expected %0h", what, got, exp));
	endtask

	// the loaded epoch shows on now right after the commit.
	task automatic check_epoch();
		check_value("tai_sec", now.tai_sec, mdl.sec);
		check_value("ns", 32'(now.ns), 32'(mdl.ns));
	endtask

	// a reload would put the committed ns back on now.
	task automatic check_free_run();
		assert (now.ns != mdl.ns)
		else report_error("counter reloaded without a seconds or nanoseconds write");
	endtask

	// utc drops the leap count and local adds the zone in hours.
	task automatic check_now();
		logic [SEC_W-1:0] exp_utc;
		logic [SEC_W-1:0] exp_local;
		int               tz_hours;
		tz_hours  = int'($signed(mdl.time_zone));
		exp_utc   = now.tai_sec - SEC_W'(mdl.leap_cnt);
		exp_local = exp_utc + SEC_W'(tz_hours * 3600);
		check_value("utc_sec", now.utc_sec, exp_utc);
		check_value("local_sec", now.local_sec, exp_local);
		check_value("quality", 32'(now.quality), 32'(mdl.quality));
		assert (now.ns < NS_PER_SEC)
		else report_error("ns reached one second");
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------

	task automatic commit_write(input timer_wr_t w);
		@(posedge clk);
		#2;
		wr        = w;
		io_update = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		io_update = 1'b1;
		// sync flops, commit, load and output stage.
		repeat (5) @(posedge clk);
		@(negedge clk);
		if (w.sec_vld) mdl.sec = w.cfg.sec;
		if (w.ns_vld) mdl.ns = w.cfg.ns;
		if (w.tz_vld) mdl.time_zone = w.cfg.time_zone;
		if (w.leap_vld) mdl.leap_cnt = w.cfg.leap_cnt;
		if (w.qlt_vld) mdl.quality = w.cfg.quality;
	endtask

	initial begin
		timer_wr_t        w;
		logic [NS_W-1:0]  exp_ns;
		logic [SEC_W-1:0] start_sec;
		int               chk_fails;
		void'($urandom(SEED));
		rst_n     = 1'b0;
		io_update = 1'b1;
		mdl       = '0;
		// a full write sits on the bus and nothing may take it.
		wr                 = '0;
		wr.cfg.sec         = $urandom();
		wr.cfg.ns          = NS_W'($urandom_range(0, 999_999_999));
		wr.cfg.time_zone   = TZ_W'($urandom());
		wr.cfg.leap_cnt    = LEAP_W'($urandom_range(1, 255));
		wr.cfg.quality     = QLT_W'($urandom_range(1, 15));
		{wr.sec_vld, wr.ns_vld, wr.tz_vld, wr.leap_vld, wr.qlt_vld} = 5'b11111;

		repeat (3) @(posedge clk);
		@(negedge clk);
		assert (now == '0 && !pps)
		else report_error("outputs not zero during reset");
		@(posedge clk);
		#2;
		rst_n = 1'b1;

		// io_update stays high through and after reset.
		repeat (12) @(posedge clk);
		@(negedge clk);
		check_value("tai_sec after reset", now.tai_sec, '0);
		check_now();
		check_value("pps pulses after reset", pps_cnt, 0);

		// counting up to the second boundary.
		w           = '0;
		w.cfg.sec   = $urandom();
		w.cfg.ns    = NS_PER_SEC - NS_STEP - NS_STEP - NS_STEP;
		w.sec_vld   = 1'b1;
		w.ns_vld    = 1'b1;
		commit_write(w);
		check_epoch();
		exp_ns    = mdl.ns;
		start_sec = mdl.sec;
		while (!pps) begin
			@(negedge clk);
			exp_ns = exp_ns + NS_STEP;
			check_value("ns step", 32'(now.ns), 32'(exp_ns));
		end
		check_value("tai_sec before carry", now.tai_sec, start_sec);
		@(negedge clk);
		assert (!pps)
		else report_error("pps high for more than one cycle");
		check_value("tai_sec after carry", now.tai_sec, start_sec + SEC_W'(1));
		check_value("ns after carry", 32'(now.ns), '0);
		check_value("pps pulses", pps_cnt, 1);

		// partial writes with a positive then a negative zone.
		w                 = '0;
		w.cfg.time_zone   = TZ_W'($urandom_range(1, 14));
		w.cfg.leap_cnt    = LEAP_W'($urandom_range(10, 255));
		w.cfg.quality     = QLT_W'($urandom());
		w.tz_vld          = 1'b1;
		w.leap_vld        = 1'b1;
		commit_write(w);
		check_now();
		check_free_run();
		w.cfg.time_zone   = TZ_W'(-int'($urandom_range(1, 12)));
		w.cfg.leap_cnt    = LEAP_W'($urandom());
		w.leap_vld        = 1'b0;
		w.qlt_vld         = 1'b1;
		commit_write(w);
		check_now();
		check_free_run();

		for (int i = 0; i < 10; i++) begin
			w               = '0;
			w.cfg.sec       = $urandom();
			w.cfg.ns        = NS_W'($urandom_range(0, 999_999_999));
			w.cfg.time_zone = TZ_W'($urandom());
			w.cfg.leap_cnt  = LEAP_W'($urandom());
			w.cfg.quality   = QLT_W'($urandom());
			{w.sec_vld, w.ns_vld, w.tz_vld, w.leap_vld, w.qlt_vld} =
				5'($urandom_range(1, 31));
			commit_write(w);
			if (w.sec_vld || w.ns_vld) begin
				check_epoch();
			end else begin
				check_free_run();
			end
			check_now();
		end

		// new write while the line stays high.
		w              = '0;
		w.cfg.quality  = ~mdl.quality;
		w.cfg.leap_cnt = mdl.leap_cnt + LEAP_W'(1);
		w.qlt_vld      = 1'b1;
		w.leap_vld     = 1'b1;
		@(posedge clk);
		#2;
		wr = w;
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_now();
		commit_write(w);
		check_now();
		check_free_run();

		repeat (4) @(posedge clk);
		chk_fails = u_tai_utc_timer_top.u_tai_utc_timer_chk.fail_cnt;
		$display("run done: %0d errors, %0d assertion failures", err_cnt, chk_fails);
		if (err_cnt == 0 && chk_fails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== tests/tai_utc_timer_chk.sv ====
`timescale 1ns/1ps

module tai_utc_timer_chk (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      time_load,
	input tai_pkg::timer_cfg_t       cfg,
	input logic [tai_pkg::SEC_W-1:0] tai_sec,
	input logic [tai_pkg::NS_W-1:0]  tai_ns,
	input logic                      pps,
	input tai_pkg::time_out_t        now
);

	import tai_pkg::*;

	int               fail_cnt = 0;
	logic [SEC_W-1:0] tz_sec;

	// zone in seconds with the hours taken as signed.
	assign tz_sec = SEC_W'(int'($signed(cfg.time_zone)) * 3600);

	// --------------------------------------------------
	// reset and counting
	// --------------------------------------------------

	a_reset: assert property (@(posedge clk) !rst_n |-> (now == '0 && !pps && !time_load))
		else begin
			fail_cnt++;
			$error("outputs not cleared in reset");
		end

	a_ns_range: assert property (@(posedge clk) disable iff (!rst_n)
		tai_ns < NS_PER_SEC && now.ns < NS_PER_SEC)
		else begin
			fail_cnt++;
			$error("ns at or above one second");
		end

	a_ns_step: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && !$past(time_load) && !pps |-> tai_ns == $past(tai_ns) + NS_STEP)
		else begin
			fail_cnt++;
			$error("ns did not step");
		end

	a_ns_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		pps |-> tai_ns == $past(tai_ns) + NS_STEP - NS_PER_SEC)
		else begin
			fail_cnt++;
			$error("ns wrong at the second boundary");
		end

	a_pps_carry: assert property (@(posedge clk) disable iff (!rst_n)
		pps |-> tai_sec == $past(tai_sec) + SEC_W'(1))
		else begin
			fail_cnt++;
			$error("pps without a seconds increment");
		end

	a_pps_single: assert property (@(posedge clk) disable iff (!rst_n) $past(pps) |-> !pps)
		else begin
			fail_cnt++;
			$error("pps wider than one cycle");
		end

	// --------------------------------------------------
	// commit and conversion
	// --------------------------------------------------

	a_load_seen: assert property (@(posedge clk) disable iff (!rst_n)
		$past(time_load, 2) |-> now.tai_sec == $past(cfg.sec, 2) && now.ns == $past(cfg.ns, 2))
		else begin
			fail_cnt++;
			$error("loaded epoch not on now");
		end

	a_utc: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> now.utc_sec == $past(tai_sec) - SEC_W'($past(cfg.leap_cnt)))
		else begin
			fail_cnt++;
			$error("utc_sec wrong");
		end

	a_local: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> now.local_sec == now.utc_sec + $past(tz_sec))
		else begin
			fail_cnt++;
			$error("local_sec wrong");
		end

	a_pass: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> now.tai_sec == $past(tai_sec) && now.ns == $past(tai_ns))
		else begin
			fail_cnt++;
			$error("tai time not passed through");
		end

endmodule

bind tai_utc_timer_top tai_utc_timer_chk u_tai_utc_timer_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.time_load (time_load),
	.cfg       (cfg),
	.tai_sec   (tai_sec),
	.tai_ns    (tai_ns),
	.pps       (pps),
	.now       (now)
);

// ==== hw/tai_utc_timer_top.sv ====
`timescale 1ns/1ps

module tai_utc_timer_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               io_update,
	input  tai_pkg::timer_wr_t wr,
	output tai_pkg::time_out_t now,
	output logic               pps
);

	import tai_pkg::*;

	timer_cfg_t       cfg;
	logic             time_load;
	logic [SEC_W-1:0] tai_sec;
	logic [NS_W-1:0]  tai_ns;

	// register set, committed on the io_update rise.
	tai_utc_timer_reg u_tai_utc_timer_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.io_update (io_update),
		.wr        (wr),
		.cfg       (cfg),
		.time_load (time_load)
	);

	tai_time_counter u_tai_time_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.time_load (time_load),
		.load_sec  (cfg.sec),
		.load_ns   (cfg.ns),
		.tai_sec   (tai_sec),
		.tai_ns    (tai_ns),
		.pps       (pps)
	);

	// now lags the counter by one cycle.
	tai_utc_convert u_tai_utc_convert (
		.clk     (clk),
		.rst_n   (rst_n),
		.tai_sec (tai_sec),
		.tai_ns  (tai_ns),
		.cfg     (cfg),
		.now     (now)
	);

endmodule

// ==== hw/tai_utc_convert.sv ====
`timescale 1ns/1ps

module tai_utc_convert (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [tai_pkg::SEC_W-1:0] tai_sec,
	input  logic [tai_pkg::NS_W-1:0]  tai_ns,
	input  tai_pkg::timer_cfg_t       cfg,
	output tai_pkg::time_out_t        now
);

	import tai_pkg::*;

	logic [SEC_W-1:0] tz_ext;
	logic [SEC_W-1:0] tz_sec;
	logic [SEC_W-1:0] utc_sec;
	logic [SEC_W-1:0] local_sec;

	// --------------------------------------------------
	// conversion
	// --------------------------------------------------

	// sign extend the zone, the product wraps like two's complement.
	assign tz_ext = SEC_W'($signed(cfg.time_zone));
	assign tz_sec = tz_ext * SEC_PER_HOUR;

	assign utc_sec   = tai_sec - SEC_W'(cfg.leap_cnt);
	assign local_sec = utc_sec + tz_sec;

	// --------------------------------------------------
	// output stage
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			now <= '0;
		end else begin
			now.tai_sec   <= tai_sec;
			now.utc_sec   <= utc_sec;
			now.local_sec <= local_sec;
			now.ns        <= tai_ns;
			now.quality   <= cfg.quality;
		end
	end

endmodule

// ==== hw/tai_time_counter.sv ====
`timescale 1ns/1ps

module tai_time_counter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      time_load,
	input  logic [tai_pkg::SEC_W-1:0] load_sec,
	input  logic [tai_pkg::NS_W-1:0]  load_ns,
	output logic [tai_pkg::SEC_W-1:0] tai_sec,
	output logic [tai_pkg::NS_W-1:0]  tai_ns,
	output logic                      pps
);

	import tai_pkg::*;

	logic [NS_W-1:0] ns_sum;
	logic [NS_W-1:0] ns_wrapped;
	logic            wrap;

	// --------------------------------------------------
	// next nanosecond value
	// --------------------------------------------------

	// fits in NS_W since tai_ns stays below NS_PER_SEC.
	assign ns_sum     = tai_ns + NS_STEP;
	assign wrap       = (ns_sum >= NS_PER_SEC);
	assign ns_wrapped = ns_sum - NS_PER_SEC;

	// --------------------------------------------------
	// counter
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tai_sec <= '0;
			tai_ns  <= '0;
			pps     <= 1'b0;
		end else if (time_load) begin
			// new epoch and no boundary marked on this edge.
			tai_sec <= load_sec;
			tai_ns  <= load_ns;
			pps     <= 1'b0;
		end else begin
			pps <= wrap;
			if (wrap) begin
				tai_ns  <= ns_wrapped;
				tai_sec <= tai_sec + SEC_W'(1);
			end else begin
				tai_ns <= ns_sum;
			end
		end
	end

endmodule

// ==== hw/tai_utc_timer_reg.sv ====
`timescale 1ns/1ps

module tai_utc_timer_reg (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                io_update,
	input  tai_pkg::timer_wr_t  wr,
	output tai_pkg::timer_cfg_t cfg,
	output logic                time_load
);

	// [0] and [1] synchronize, [2] holds the previous synced level.
	logic [2:0] upd_sync;
	logic       upd_rise;
	logic       epoch_wr;

	// --------------------------------------------------
	// io_update edge catch
	// --------------------------------------------------

	// ones at reset so a line held high commits nothing.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			upd_sync <= 3'b111;
		end else begin
			upd_sync <= {upd_sync[1:0], io_update};
		end
	end

	assign upd_rise = upd_sync[1] & ~upd_sync[2];

	// a new epoch only when seconds or nanoseconds are written.
	assign epoch_wr = wr.sec_vld | wr.ns_vld;

	// --------------------------------------------------
	// field commit
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (upd_rise) begin
			if (wr.sec_vld) begin
				cfg.sec <= wr.cfg.sec;
			end
			if (wr.ns_vld) begin
				cfg.ns <= wr.cfg.ns;
			end
			if (wr.tz_vld) begin
				cfg.time_zone <= wr.cfg.time_zone;
			end
			if (wr.leap_vld) begin
				cfg.leap_cnt <= wr.cfg.leap_cnt;
			end
			if (wr.qlt_vld) begin
				cfg.quality <= wr.cfg.quality;
			end
		end
	end

	// load strobe lines up with the committed fields.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_load <= 1'b0;
		end else begin
			time_load <= upd_rise & epoch_wr;
		end
	end

endmodule

// ==== hw/tai_pkg.sv ====
package tai_pkg;

	// --------------------------------------------------
	// field widths
	// --------------------------------------------------

	// seconds since the TAI epoch.
	localparam int SEC_W  = 32;
	// nanoseconds within the current second.
	localparam int NS_W   = 30;
	// whole hours, two's complement.
	localparam int TZ_W   = 6;
	localparam int LEAP_W = 8;
	localparam int QLT_W  = 4;

	// --------------------------------------------------
	// counting constants
	// --------------------------------------------------

	// wrap point of the nanosecond field.
	localparam logic [NS_W-1:0] NS_PER_SEC = NS_W'(1_000_000_000);
	// 25 MHz clock, 40 ns per tick.
	localparam logic [NS_W-1:0] NS_STEP = NS_W'(40);
	localparam logic [SEC_W-1:0] SEC_PER_HOUR = SEC_W'(3600);

	// --------------------------------------------------
	// field structs
	// --------------------------------------------------

	// committed register values, 80 bits.
	typedef struct packed {
		logic [SEC_W-1:0]  sec;
		logic [NS_W-1:0]   ns;
		logic [TZ_W-1:0]   time_zone;
		logic [LEAP_W-1:0] leap_cnt;
		logic [QLT_W-1:0]  quality;
	} timer_cfg_t;

	// software write, one valid bit per field.
	typedef struct packed {
		timer_cfg_t cfg;
		logic       sec_vld;
		logic       ns_vld;
		logic       tz_vld;
		logic       leap_vld;
		logic       qlt_vld;
	} timer_wr_t;

	// published time of day.
	typedef struct packed {
		logic [SEC_W-1:0] tai_sec;
		logic [SEC_W-1:0] utc_sec;
		logic [SEC_W-1:0] local_sec;
		logic [NS_W-1:0]  ns;
		logic [QLT_W-1:0] quality;
	} time_out_t;

endpackage
